// File: hw/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// data and address width of the core
`define XLEN 32

// word count of the shared RAM, indexed by address bits 9:2
`define MEM_DEPTH_WORDS 256

// mcause codes for misaligned accesses
`define MCAUSE_LOAD_MISALIGNED 31'd4
`define MCAUSE_STORE_MISALIGNED 31'd6

`define FETCH_RESET_WORD 32'h0000_0013  // addi x0, x0, 0

`endif

// File: hw/mem_pkg.sv
`include "mem_defines.svh"

package mem_pkg;

  // bit 4 marks a memory op, bit 3 a store, bits 2:0 the RISC-V width code
  typedef enum logic [4:0] {
    MEM_NONE = 5'b00000,
    MEM_LB   = 5'b10000,
    MEM_LH   = 5'b10001,
    MEM_LW   = 5'b10010,
    MEM_LBU  = 5'b10100,
    MEM_LHU  = 5'b10101,
    MEM_SB   = 5'b11000,
    MEM_SH   = 5'b11001,
    MEM_SW   = 5'b11010
  } mem_op_e;

  typedef struct packed {
    logic              valid;
    logic [30:0]       mcause;
    logic [`XLEN-1:0]  pc;
    logic [31:0]       insn;
  } trap_info_t;

  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  pc;
    logic [31:0]       insn;
    logic [4:0]        rd_addr;
    mem_op_e           mem_op;
    logic [`XLEN-1:0]  alu_result;   // effective address for memory ops
    logic [`XLEN-1:0]  store_wdata;
    trap_info_t        carried_trap;
  } ex_mem_t;

  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  pc;
    logic [31:0]       insn;
    logic [4:0]        rd_addr;
    logic [`XLEN-1:0]  alu_result;
    logic [3:0]        load_rmask;
    logic [`XLEN-1:0]  load_rdata;
    logic [3:0]        store_wmask;
    logic [`XLEN-1:0]  store_wdata;
    trap_info_t        carried_trap;
  } mem_wb_t;

  typedef struct packed {
    logic [`XLEN-1:0]  addr;
    logic              wen;
    logic [`XLEN-1:0]  wdata;
    logic [3:0]        strb;
  } mem_req_t;

  typedef struct packed {
    logic [`XLEN-1:0]  rdata;
  } mem_rsp_t;

endpackage

// File: hw/store_unit.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module store_unit
  import mem_pkg::*;
(
  input  mem_op_e          mem_op_i,
  input  logic [1:0]       addr_lsb_i,
  input  logic [`XLEN-1:0] wdata_raw_i,
  output logic             trap_valid_o,
  output logic [30:0]      trap_mcause_o,
  output logic [3:0]       wmask_o,
  output logic [`XLEN-1:0] wdata_o
);
  logic is_store;
  logic misaligned;

  assign is_store = mem_op_i[4] & mem_op_i[3];

  always_comb begin
    misaligned = 1'b0;
    wmask_o    = '0;
    wdata_o    = '0;
    if (is_store) begin
      case (mem_op_i[1:0])
        2'b00: begin
          wdata_o = {4{wdata_raw_i[7:0]}};  // byte goes to every lane
          wmask_o = 4'b0001 << addr_lsb_i;
        end
        2'b01: begin
          misaligned = addr_lsb_i[0];
          wdata_o    = {2{wdata_raw_i[15:0]}};
          wmask_o    = 4'b0011 << addr_lsb_i;
        end
        default: begin
          misaligned = |addr_lsb_i;
          wdata_o    = wdata_raw_i;
          wmask_o    = 4'b1111;
        end
      endcase
      if (misaligned) wmask_o = '0;  // a trapping store must not touch memory
    end
    trap_valid_o  = misaligned;
    trap_mcause_o = misaligned ? `MCAUSE_STORE_MISALIGNED : '0;
  end

endmodule

// File: hw/load_unit.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module load_unit
  import mem_pkg::*;
(
  input  mem_op_e          mem_op_i,
  input  logic [1:0]       addr_lsb_i,
  input  logic [`XLEN-1:0] rdata_raw_i,
  output logic             trap_valid_o,
  output logic [30:0]      trap_mcause_o,
  output logic [3:0]       rmask_o,
  output logic [`XLEN-1:0] rdata_o
);
  logic             is_load;
  logic             is_unsigned;
  logic             misaligned;
  logic [`XLEN-1:0] lane;

  assign is_load     = mem_op_i[4] & ~mem_op_i[3];
  assign is_unsigned = mem_op_i[2];  // LBU and LHU
  assign lane        = rdata_raw_i >> {addr_lsb_i, 3'b000};  // addressed byte to bit 0

  always_comb begin
    misaligned = 1'b0;
    rmask_o    = '0;
    rdata_o    = '0;
    if (is_load) begin
      case (mem_op_i[1:0])
        2'b00: begin
          rmask_o = 4'b0001 << addr_lsb_i;
          rdata_o = {{24{~is_unsigned & lane[7]}}, lane[7:0]};
        end
        2'b01: begin
          misaligned = addr_lsb_i[0];
          rmask_o    = 4'b0011 << addr_lsb_i;
          rdata_o    = {{16{~is_unsigned & lane[15]}}, lane[15:0]};
        end
        default: begin
          misaligned = |addr_lsb_i;
          rmask_o    = 4'b1111;
          rdata_o    = lane;
        end
      endcase
      if (misaligned) begin
        rmask_o = '0;
        rdata_o = '0;
      end
    end
    trap_valid_o  = misaligned;
    trap_mcause_o = misaligned ? `MCAUSE_LOAD_MISALIGNED : '0;
  end

endmodule

// File: hw/mem_stage.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module mem_stage
  import mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  ex_mem_t  ex_mem_i,
  output mem_wb_t  wb_o,
  output logic     stage_done_o,
  output logic     mem_valid_o,
  output mem_req_t mem_req_o,
  input  logic     mem_done_i,
  input  mem_rsp_t mem_rsp_i
);
  trap_info_t       trap;
  logic             store_trap_valid;
  logic [30:0]      store_trap_mcause;
  logic             load_trap_valid;
  logic [30:0]      load_trap_mcause;
  logic [3:0]       store_wmask;
  logic [3:0]       load_rmask;
  logic [`XLEN-1:0] store_wdata;
  logic [`XLEN-1:0] load_rdata;
  logic             is_store;
  logic             needs_mem;
  logic             start_q;
  logic             in_flight_q;

  store_unit u_store_unit (
    .mem_op_i      (ex_mem_i.mem_op),
    .addr_lsb_i    (ex_mem_i.alu_result[1:0]),
    .wdata_raw_i   (ex_mem_i.store_wdata),
    .trap_valid_o  (store_trap_valid),
    .trap_mcause_o (store_trap_mcause),
    .wmask_o       (store_wmask),
    .wdata_o       (store_wdata)
  );

  load_unit u_load_unit (
    .mem_op_i      (ex_mem_i.mem_op),
    .addr_lsb_i    (ex_mem_i.alu_result[1:0]),
    .rdata_raw_i   (mem_rsp_i.rdata),
    .trap_valid_o  (load_trap_valid),
    .trap_mcause_o (load_trap_mcause),
    .rmask_o       (load_rmask),
    .rdata_o       (load_rdata)
  );

  // an older trap wins over anything raised here
  always_comb begin
    trap = '0;
    if (ex_mem_i.carried_trap.valid) begin
      trap = ex_mem_i.carried_trap;
    end else if (store_trap_valid) begin
      trap = '{valid: 1'b1, mcause: store_trap_mcause, pc: ex_mem_i.pc, insn: ex_mem_i.insn};
    end else if (load_trap_valid) begin
      trap = '{valid: 1'b1, mcause: load_trap_mcause, pc: ex_mem_i.pc, insn: ex_mem_i.insn};
    end
  end

  assign is_store  = ex_mem_i.mem_op[4] & ex_mem_i.mem_op[3];
  assign needs_mem = ex_mem_i.valid && ex_mem_i.mem_op[4] && !trap.valid;

  // the start pulse fires once per operation and waits out any request still in flight
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      start_q     <= 1'b0;
      in_flight_q <= 1'b0;
    end else begin
      start_q <= needs_mem && !start_q && !in_flight_q && !mem_done_i;
      if (mem_done_i) begin
        in_flight_q <= 1'b0;
      end else if (start_q) begin
        in_flight_q <= 1'b1;
      end
    end
  end

  assign mem_valid_o = start_q;
  assign mem_req_o   = '{addr: ex_mem_i.alu_result, wen: is_store,
                         wdata: store_wdata, strb: store_wmask};

  assign stage_done_o = ex_mem_i.valid && (!needs_mem || (in_flight_q && mem_done_i));

  always_comb begin
    wb_o              = '0;
    wb_o.valid        = stage_done_o;
    wb_o.pc           = ex_mem_i.pc;
    wb_o.insn         = ex_mem_i.insn;
    wb_o.rd_addr      = ex_mem_i.rd_addr;
    wb_o.alu_result   = ex_mem_i.alu_result;
    wb_o.carried_trap = trap;
    if (needs_mem) begin  // masks stay zero for traps and non-memory ops
      wb_o.load_rmask  = load_rmask;
      wb_o.load_rdata  = load_rdata;
      wb_o.store_wmask = store_wmask;
      wb_o.store_wdata = store_wdata;
    end
  end

endmodule

// File: hw/fetch_port.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module fetch_port
  import mem_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             fetch_req_i,
  input  logic [`XLEN-1:0] fetch_pc_i,
  output logic [31:0]      fetch_insn_o,
  output logic             fetch_done_o,
  output logic             mem_valid_o,
  output mem_req_t         mem_req_o,
  input  logic             mem_done_i,
  input  mem_rsp_t         mem_rsp_i
);
  mem_req_t    req_q;
  logic        accept;
  logic        valid_q;
  logic        busy_q;
  logic        done_q;
  logic [31:0] insn_q;

  assign accept = fetch_req_i && !busy_q;  // requests during a fetch are dropped

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      insn_q  <= `FETCH_RESET_WORD;
    end else begin
      valid_q <= accept;
      done_q  <= busy_q && mem_done_i;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (mem_done_i) begin
        busy_q <= 1'b0;
      end
      if (busy_q && mem_done_i) insn_q <= mem_rsp_i.rdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= '{addr: {fetch_pc_i[`XLEN-1:2], 2'b00}, wen: 1'b0, wdata: '0, strb: 4'b0000};
    end
  end

  assign mem_valid_o  = valid_q;
  assign mem_req_o    = req_q;
  assign fetch_done_o = done_q;
  assign fetch_insn_o = insn_q;

endmodule

// File: hw/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter
  import mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     dreq_valid_i,
  input  mem_req_t dreq_i,
  output logic     dreq_done_o,
  output mem_rsp_t drsp_o,
  input  logic     ireq_valid_i,
  input  mem_req_t ireq_i,
  output logic     ireq_done_o,
  output mem_rsp_t irsp_o,
  output logic     ram_valid_o,
  output mem_req_t ram_req_o,
  input  logic     ram_done_i,
  input  mem_rsp_t ram_rsp_i
);
  logic d_pending_q;
  logic i_pending_q;
  logic busy_q;
  logic owner_instr_q;  // set while the fetch port holds the grant
  logic d_req;
  logic i_req;
  logic grant;
  logic grant_instr;
  logic sel_instr;

  // a fresh pulse counts as pending in the cycle it arrives
  assign d_req = dreq_valid_i | d_pending_q;
  assign i_req = ireq_valid_i | i_pending_q;

  assign grant       = !busy_q && (d_req || i_req);
  assign grant_instr = !d_req;  // data side always wins a tie
  assign sel_instr   = busy_q ? owner_instr_q : grant_instr;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      d_pending_q   <= 1'b0;
      i_pending_q   <= 1'b0;
      busy_q        <= 1'b0;
      owner_instr_q <= 1'b0;
    end else begin
      d_pending_q <= d_req && !(grant && !grant_instr);
      i_pending_q <= i_req && !(grant && grant_instr);
      if (grant) begin
        busy_q        <= 1'b1;
        owner_instr_q <= grant_instr;
      end else if (ram_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // requesters hold their payload until done, so the mux can select it live
  assign ram_valid_o = grant;
  assign ram_req_o   = sel_instr ? ireq_i : dreq_i;

  assign dreq_done_o = ram_done_i && busy_q && !owner_instr_q;
  assign ireq_done_o = ram_done_i && busy_q && owner_instr_q;
  assign drsp_o      = ram_rsp_i;
  assign irsp_o      = ram_rsp_i;

endmodule

// File: hw/data_ram.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module data_ram
  import mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  input  mem_req_t req_i,
  output logic     done_o,
  output mem_rsp_t rsp_o
);
  localparam int unsigned IDX_W = $clog2(`MEM_DEPTH_WORDS);

  logic [`XLEN-1:0] mem_q [`MEM_DEPTH_WORDS];
  logic [IDX_W-1:0] idx;
  mem_rsp_t         rsp_q;
  logic             done_q;

  assign idx = req_i.addr[IDX_W+1:2];  // word index without the byte offset

  // read returns the word as it was before a write in the same cycle
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rsp_q.rdata <= mem_q[idx];
      if (req_i.wen) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.strb[b]) mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= valid_i;
    end
  end

  assign done_o = done_q;
  assign rsp_o  = rsp_q;

endmodule

// File: hw/mem_subsystem.sv
`timescale 1ns/10ps

module mem_subsystem
  import mem_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  ex_mem_t     ex_mem_i,
  output mem_wb_t     wb_o,
  output logic        stage_done_o,
  input  logic        fetch_req_i,
  input  logic [31:0] fetch_pc_i,
  output logic [31:0] fetch_insn_o,
  output logic        fetch_done_o
);
  logic     d_valid;
  mem_req_t d_req;
  logic     d_done;
  mem_rsp_t d_rsp;
  logic     i_valid;
  mem_req_t i_req;
  logic     i_done;
  mem_rsp_t i_rsp;
  logic     ram_valid;
  mem_req_t ram_req;
  logic     ram_done;
  mem_rsp_t ram_rsp;

  mem_stage u_mem_stage (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ex_mem_i     (ex_mem_i),
    .wb_o         (wb_o),
    .stage_done_o (stage_done_o),
    .mem_valid_o  (d_valid),
    .mem_req_o    (d_req),
    .mem_done_i   (d_done),
    .mem_rsp_i    (d_rsp)
  );

  fetch_port u_fetch_port (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .fetch_req_i  (fetch_req_i),
    .fetch_pc_i   (fetch_pc_i),
    .fetch_insn_o (fetch_insn_o),
    .fetch_done_o (fetch_done_o),
    .mem_valid_o  (i_valid),
    .mem_req_o    (i_req),
    .mem_done_i   (i_done),
    .mem_rsp_i    (i_rsp)
  );

  mem_arbiter u_mem_arbiter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .dreq_valid_i (d_valid),
    .dreq_i       (d_req),
    .dreq_done_o  (d_done),
    .drsp_o       (d_rsp),
    .ireq_valid_i (i_valid),
    .ireq_i       (i_req),
    .ireq_done_o  (i_done),
    .irsp_o       (i_rsp),
    .ram_valid_o  (ram_valid),
    .ram_req_o    (ram_req),
    .ram_done_i   (ram_done),
    .ram_rsp_i    (ram_rsp)
  );

  data_ram u_data_ram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (ram_valid),
    .req_i   (ram_req),
    .done_o  (ram_done),
    .rsp_o   (ram_rsp)
  );

endmodule

// File: verification/mem_checker.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module mem_checker
  import mem_pkg::*;
(
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        stage_done_i,
  input mem_wb_t     wb_i,
  input logic        fetch_done_i,
  input logic [31:0] fetch_insn_i
);
  string       stage_names [$];
  mem_wb_t     stage_exp [$];
  string       fetch_names [$];
  logic [31:0] fetch_exp [$];
  int          pass_count = 0;
  int          fail_count = 0;

  task automatic expect_stage(input string name, input mem_wb_t exp);
    stage_names.push_back(name);
    stage_exp.push_back(exp);
  endtask

  task automatic expect_fetch(input string name, input logic [31:0] exp);
    fetch_names.push_back(name);
    fetch_exp.push_back(exp);
  endtask

  task automatic report_failure(input string name, input string what);
    $display("failure %s: %s", name, what);
    fail_count++;
  endtask

  task automatic check_reset_state(input string name);
    if (fetch_insn_i !== `FETCH_RESET_WORD) begin
      $display("error %s: expected %h actual %h", name, `FETCH_RESET_WORD, fetch_insn_i);
      fail_count++;
    end else if (stage_done_i !== 1'b0 || fetch_done_i !== 1'b0) begin
      report_failure(name, "a done output is high while the subsystem is idle");
    end else begin
      $display("pass %s", name);
      pass_count++;
    end
  endtask

  task automatic print_summary();
    $display("tests finished: %0d passed, %0d failed", pass_count, fail_count);
  endtask

  // outputs settle after the rising edge, so the falling edge is a safe sample point
  always @(negedge clk_i) begin : watch
    string       name;
    mem_wb_t     exp_wb;
    logic [31:0] exp_insn;
    if (rst_n_i && stage_done_i === 1'b1) begin
      if (stage_names.size() == 0) begin
        report_failure("stray_stage_done", "stage_done_o rose with no operation pending");
      end else begin
        name   = stage_names.pop_front();
        exp_wb = stage_exp.pop_front();
        if (wb_i !== exp_wb) begin
          $display("error %s: expected %h actual %h", name, exp_wb, wb_i);
          fail_count++;
        end else begin
          $display("pass %s", name);
          pass_count++;
        end
      end
    end
    if (rst_n_i && fetch_done_i === 1'b1) begin
      if (fetch_names.size() == 0) begin
        report_failure("stray_fetch_done", "fetch_done_o rose with no fetch pending");
      end else begin
        name     = fetch_names.pop_front();
        exp_insn = fetch_exp.pop_front();
        if (fetch_insn_i !== exp_insn) begin
          $display("error %s: expected %h actual %h", name, exp_insn, fetch_insn_i);
          fail_count++;
        end else begin
          $display("pass %s", name);
          pass_count++;
        end
      end
    end
  end

endmodule

// File: verification/mem_subsystem_tb.sv
`timescale 1ns/10ps

module mem_subsystem_tb
  import mem_pkg::*;
();
  localparam int FILL_WORDS   = 16;  // words 0x00 to 0x3c hold every address the tests touch
  localparam int RANDOM_OPS   = 40;
  localparam int DONE_TIMEOUT = 20;
  localparam int NUM_TESTS    = 1 + FILL_WORDS + 35 + 2 * RANDOM_OPS;

  logic        clk;
  logic        rst_n;
  ex_mem_t     ex_mem;
  mem_wb_t     wb;
  logic        stage_done;
  logic        fetch_req;
  logic [31:0] fetch_pc;
  logic [31:0] fetch_insn;
  logic        fetch_done;
  logic [31:0] shadow_mem [256];
  integer      seed = 63;
  int          op_count = 0;
  mem_op_e     op_list [9] = '{MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
                               MEM_SB, MEM_SH, MEM_SW};

  mem_subsystem DUT (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .ex_mem_i     (ex_mem),
    .wb_o         (wb),
    .stage_done_o (stage_done),
    .fetch_req_i  (fetch_req),
    .fetch_pc_i   (fetch_pc),
    .fetch_insn_o (fetch_insn),
    .fetch_done_o (fetch_done)
  );

  mem_checker CHK (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .stage_done_i (stage_done),
    .wb_i         (wb),
    .fetch_done_i (fetch_done),
    .fetch_insn_i (fetch_insn)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (NUM_TESTS * 50) @(posedge clk);
    $display("watchdog expired after %0d cycles before the tests finished", NUM_TESTS * 50);
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0c3f;
  endfunction

  function automatic ex_mem_t make_op(input mem_op_e kind, input logic [31:0] addr,
                                      input logic [31:0] wdata);
    ex_mem_t op;
    op = '0;
    op.valid       = 1'b1;
    op.pc          = 32'h0000_1000 + op_count * 4;
    op.insn        = {op.pc[19:0], 12'h023};
    op.rd_addr     = op.pc[6:2];
    op.mem_op      = kind;
    op.alu_result  = addr;
    op.store_wdata = wdata;
    op_count++;
    return op;
  endfunction

  // computes the expected writeback and applies stores to the shadow memory
  function automatic mem_wb_t ref_stage(input ex_mem_t op);
    mem_wb_t     exp;
    int          size;
    int          b;
    logic        load;
    logic        sext;
    logic [1:0]  off;
    logic [3:0]  lanes;
    logic [31:0] data;
    off  = op.alu_result[1:0];
    load = 1'b1;
    sext = 1'b0;
    case (op.mem_op)
      MEM_LB: begin
        size = 1;
        sext = 1'b1;
      end
      MEM_LH: begin
        size = 2;
        sext = 1'b1;
      end
      MEM_LW:  size = 4;
      MEM_LBU: size = 1;
      MEM_LHU: size = 2;
      MEM_SB: begin
        size = 1;
        load = 1'b0;
      end
      MEM_SH: begin
        size = 2;
        load = 1'b0;
      end
      MEM_SW: begin
        size = 4;
        load = 1'b0;
      end
      default: size = 0;
    endcase
    exp            = '0;
    exp.valid      = 1'b1;
    exp.pc         = op.pc;
    exp.insn       = op.insn;
    exp.rd_addr    = op.rd_addr;
    exp.alu_result = op.alu_result;
    if (op.carried_trap.valid) begin
      exp.carried_trap = op.carried_trap;
    end else if ((size == 2 && off[0]) || (size == 4 && off != 2'd0)) begin
      exp.carried_trap = '{1'b1, load ? 31'd4 : 31'd6, op.pc, op.insn};
    end
    if (size != 0 && !exp.carried_trap.valid) begin
      lanes = (size == 1) ? 4'b0001 : (size == 2) ? 4'b0011 : 4'b1111;
      lanes = lanes << off;
      if (load) begin
        data = shadow_mem[op.alu_result[9:2]] >> (8 * off);
        if (size == 1) data = {{24{sext & data[7]}}, data[7:0]};
        if (size == 2) data = {{16{sext & data[15]}}, data[15:0]};
        exp.load_rmask = lanes;
        exp.load_rdata = data;
      end else begin
        data = (size == 1) ? {4{op.store_wdata[7:0]}} :
               (size == 2) ? {2{op.store_wdata[15:0]}} : op.store_wdata;
        exp.store_wmask = lanes;
        exp.store_wdata = data;
        for (b = 0; b < 4; b++) begin
          if (lanes[b]) shadow_mem[op.alu_result[9:2]][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
    return exp;
  endfunction

  task automatic run_stage(input string name, input ex_mem_t op);
    int waited;
    CHK.expect_stage(name, ref_stage(op));
    @(posedge clk);
    #1 ex_mem = op;
    waited = 0;
    @(negedge clk);
    while (stage_done !== 1'b1 && waited < DONE_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (stage_done !== 1'b1) begin
      CHK.report_failure(name, "stage_done_o never rose for this operation");
    end
    @(posedge clk);
    #1 ex_mem = '0;
  endtask

  task automatic run_fetch(input string name, input logic [31:0] pc);
    int waited;
    CHK.expect_fetch(name, shadow_mem[pc[9:2]]);
    @(posedge clk);
    #1 fetch_pc = pc;
    fetch_req = 1'b1;
    @(posedge clk);
    #1 fetch_req = 1'b0;
    waited = 0;
    @(negedge clk);
    while (fetch_done !== 1'b1 && waited < DONE_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (fetch_done !== 1'b1) CHK.report_failure(name, "fetch_done_o never rose for this fetch");
  endtask

  // the fetch address never shares a word with the stage access
  task automatic run_pair(input string sname, input ex_mem_t op, input string fname,
                          input logic [31:0] pc);
    fork
      run_stage(sname, op);
      run_fetch(fname, pc);
    join
  endtask

  initial begin : stimulus
    ex_mem_t     op;
    logic [31:0] addr;
    int          k;
    int          pick;
    rst_n     = 1'b0;
    ex_mem    = '0;
    fetch_req = 1'b0;
    fetch_pc  = '0;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (8) @(posedge clk);
    #1 CHK.check_reset_state("reset_idle");
    for (k = 0; k < FILL_WORDS; k++) begin
      run_stage($sformatf("fill_w%0d", k), make_op(MEM_SW, k * 4, fill_word(k * 4)));
    end
    run_stage("sw_word", make_op(MEM_SW, 32'h10, 32'h8765_43a9));
    for (k = 0; k < 4; k++) begin
      run_stage($sformatf("lb_off%0d", k), make_op(MEM_LB, 32'h10 + k, '0));
      run_stage($sformatf("lbu_off%0d", k), make_op(MEM_LBU, 32'h10 + k, '0));
    end
    for (k = 0; k < 4; k += 2) begin
      run_stage($sformatf("lh_off%0d", k), make_op(MEM_LH, 32'h10 + k, '0));
      run_stage($sformatf("lhu_off%0d", k), make_op(MEM_LHU, 32'h10 + k, '0));
    end
    run_stage("lw_word", make_op(MEM_LW, 32'h10, '0));
    run_stage("sb_lane1", make_op(MEM_SB, 32'h11, 32'h1234_56f0));
    run_stage("sh_upper", make_op(MEM_SH, 32'h16, 32'hcafe_8001));
    run_stage("lw_after_sb", make_op(MEM_LW, 32'h10, '0));
    run_stage("lw_after_sh", make_op(MEM_LW, 32'h14, '0));
    run_stage("lh_misaligned", make_op(MEM_LH, 32'h21, '0));
    run_stage("lw_misaligned", make_op(MEM_LW, 32'h22, '0));
    run_stage("lhu_misaligned", make_op(MEM_LHU, 32'h23, '0));
    run_stage("sh_misaligned", make_op(MEM_SH, 32'h23, 32'hffff_ffff));
    run_stage("sw_misaligned", make_op(MEM_SW, 32'h25, 32'hffff_ffff));
    run_stage("lw_unchanged_20", make_op(MEM_LW, 32'h20, '0));
    run_stage("lw_unchanged_24", make_op(MEM_LW, 32'h24, '0));
    op = make_op(MEM_SW, 32'h26, 32'hdead_beef);
    op.carried_trap = '{1'b1, 31'd2, 32'h0000_0f00, 32'h0000_ffff};
    run_stage("carried_over_misaligned", op);
    op = make_op(MEM_SW, 32'h24, 32'hdead_beef);
    op.carried_trap = '{1'b1, 31'd1, 32'h0000_0f04, 32'h1234_0073};
    run_stage("carried_blocks_store", op);
    run_stage("lw_after_carried", make_op(MEM_LW, 32'h24, '0));
    run_stage("no_mem_op", make_op(MEM_NONE, 32'h1234_5678, 32'h9abc_def0));
    run_pair("pair_lw", make_op(MEM_LW, 32'h10, '0), "pair_fetch_30", 32'h30);
    run_pair("pair_sw", make_op(MEM_SW, 32'h38, 32'h0bad_f00d), "pair_fetch_3c", 32'h3c);
    run_fetch("fetch_after_sw", 32'h38);
    run_fetch("fetch_unaligned_pc", 32'h3a);  // low pc bits are dropped by the port
    for (k = 0; k < RANDOM_OPS; k++) begin
      addr = $random(seed) & 32'h3f;
      pick = ($random(seed) & 32'hff) % 9;
      op   = make_op(op_list[pick], addr, $random(seed));
      if (($random(seed) & 7) == 0) op.carried_trap = '{1'b1, 31'd11, op.pc, op.insn};
      if ($random(seed) & 1) begin
        run_pair($sformatf("rand_op%0d", k), op, $sformatf("rand_fetch%0d", k),
                 (addr + 32) & 32'h3c);
      end else begin
        run_stage($sformatf("rand_op%0d", k), op);
      end
    end
    repeat (5) @(posedge clk);
    CHK.print_summary();
    if (CHK.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+hw
hw/mem_pkg.sv
hw/store_unit.sv
hw/load_unit.sv
hw/mem_stage.sv
hw/fetch_port.sv
hw/mem_arbiter.sv
hw/data_ram.sv
hw/mem_subsystem.sv
verification/mem_checker.sv
verification/mem_subsystem_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= mem_subsystem_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
PASS_MSG  := RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the output is kept in a shell variable, shown, then searched for the pass line
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
